//--- filelist.f
+incdir+include
hw/elk_mem_pkg.sv
hw/elk_sd_pkg.sv
hw/elk_bank_decode.sv
hw/elk_spram.sv
hw/elk_mem_sys.sv
hw/elk_sd_route.sv
hw/elk_glue_top.sv
tb/tb_elk_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the glue testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_elk_glue -o sim_elk_glue
status=0
./obj_dir/sim_elk_glue > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -eq 0 ] && grep -qx "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1

//--- include/elk_tb_model.svh
// Testbench reference model for the Electron glue
// Bank map, ROM and RAM image arrays
// Loader and RAM write rules, SD routing and LED rules
`ifndef ELK_TB_MODEL_SVH
`define ELK_TB_MODEL_SVH

byte_t model_rom [ROM_WORDS];
byte_t model_ram [RAM_WORDS];

// ROM bank map, returns the hit flag
function automatic bit model_rom_map(input mem_addr_t a, output mem_idx_t idx);
	slot_t slot;
	int    bank;
	slot = a[MEM_ADDR_W-1:OFF_W];
	bank = -1;
	case (slot)
		5'b0_01_00: bank = 0;
		5'b0_10_00, 5'b0_10_01: bank = 1;
		5'b0_10_10, 5'b0_10_11: bank = 2;
		5'b0_11_00: bank = 3;
		5'b0_11_01: bank = 4;
		5'b0_11_10: bank = 5;
		5'b0_11_11: bank = 6;
		default: bank = -1;
	endcase
	idx = {bank[BANK_W-1:0], a[OFF_W-1:0]};
	return (bank >= 0);
endfunction

// RAM bank map, slots 1_00_00 to 1_01_11
function automatic bit model_ram_map(input mem_addr_t a, output mem_idx_t idx);
	idx = a[IDX_W-1:0];
	return (a[MEM_ADDR_W-1 -: 2] == 2'b10);
endfunction

// Expected read data, empty slots at zero
function automatic byte_t model_read(input mem_addr_t a);
	mem_idx_t idx;
	if (a[RAM_SPACE_BIT]) begin
		return model_ram_map(a, idx) ? model_ram[idx] : '0;
	end
	return model_rom_map(a, idx) ? model_rom[idx] : '0;
endfunction

// Download strobe, lands only in reset with the ROM index
function automatic void model_load(input load_addr_t la, input byte_t index,
		input byte_t d, input bit core_reset);
	if (core_reset && (index == LOAD_INDEX_ROM) && (la[IDX_W-1:0] < ROM_WORDS)) begin
		model_rom[la[IDX_W-1:0]] = d;
	end
endfunction

// First low cycle of a we_n pulse, ROM space ignored
function automatic void model_write(input mem_addr_t a, input byte_t d);
	mem_idx_t idx;
	if (model_ram_map(a, idx)) begin
		model_ram[idx] = d;
	end
endfunction

// Routed SPI outputs for the given card select
function automatic void model_sd_route(input bit vsd_sel, input bit sck, input bit mosi,
		input bit ss, input bit card_miso, input bit vsd_miso, output bit sd_miso,
		output bit card_sck, output bit card_mosi, output bit card_cs, output bit vsd_ss);
	sd_miso   = vsd_sel ? vsd_miso : card_miso;
	card_sck  = vsd_sel ? 1'b0 : sck;
	card_mosi = vsd_sel ? 1'b0 : mosi;
	card_cs   = vsd_sel ? 1'b1 : ss;
	vsd_ss    = vsd_sel ? ss : 1'b1;
endfunction

// LED rules from select and activity
function automatic bit model_led_user(input bit load_download, input bit vsd_sel,
		input bit active);
	return load_download | (vsd_sel & active);
endfunction

function automatic bit model_led_disk(input bit vsd_sel, input bit active);
	return ~vsd_sel & active;
endfunction

`endif

//--- tb/tb_elk_glue.sv
// Testbench for the Electron board glue
// Clock and reset, random stimulus from a fixed seed
// ROM loader, empty slots, sideways RAM, SD routing, activity LEDs
module tb_elk_glue
	import elk_mem_pkg::*;
	import elk_sd_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// Short hold so the LED fall is quick to reach
	localparam act_cnt_t HOLD = 22'd64;
	localparam int WAIT_LIMIT = 200;

	`include "elk_tb_model.svh"

	logic       clk_sys;
	logic       arst_n;
	logic       core_reset;
	mem_addr_t  mem_addr;
	byte_t      mem_wdata;
	logic       mem_we_n;
	byte_t      mem_rdata;
	logic       load_wr;
	load_addr_t load_addr;
	byte_t      load_index;
	byte_t      load_data;
	logic       load_download;
	logic       sd_sck, sd_mosi, sd_ss, sd_miso;
	logic       card_sck, card_mosi, card_cs, card_miso;
	logic       vsd_ss, vsd_miso, img_mounted, img_nonempty;
	logic       led_user, led_disk_act;

	integer    seed = 32'he38d46bc;
	bit        vsd_sel_m;
	int        checks;
	int        errors;
	int        tests_run;
	int        tests_failed;
	int        test_checks;
	int        test_errors;
	mem_idx_t  rom_used[$];
	mem_addr_t ram_used[$];

	elk_glue_top #(
		.act_hold (HOLD)
	) elk_glue_top_inst (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.core_reset    (core_reset),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_we_n      (mem_we_n),
		.mem_rdata     (mem_rdata),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_index    (load_index),
		.load_data     (load_data),
		.load_download (load_download),
		.sd_sck        (sd_sck),
		.sd_mosi       (sd_mosi),
		.sd_ss         (sd_ss),
		.sd_miso       (sd_miso),
		.card_sck      (card_sck),
		.card_mosi     (card_mosi),
		.card_cs       (card_cs),
		.card_miso     (card_miso),
		.vsd_ss        (vsd_ss),
		.vsd_miso      (vsd_miso),
		.img_mounted   (img_mounted),
		.img_nonempty  (img_nonempty),
		.led_user      (led_user),
		.led_disk_act  (led_disk_act)
	);

	// 100 ns period
	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check_val(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		test_checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, sig, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		test_checks++;
		assert (ok) else begin
			$display("ERROR at %0d ns: %s", $time, what);
			test_errors++;
		end
	endtask

	task automatic start_test();
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test(input string name);
		$display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		tests_run++;
		checks += test_checks;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
	endtask

	// Address held two cycles, data sampled mid cycle
	task automatic read_check(input mem_addr_t a);
		@(posedge clk_sys);
		mem_addr <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_val("mem_rdata", mem_rdata, model_read(a));
	endtask

	// One strobe cycle on the download port
	task automatic load_byte(input load_addr_t la, input byte_t index, input byte_t d);
		@(posedge clk_sys);
		load_wr    <= 1'b1;
		load_addr  <= la;
		load_index <= index;
		load_data  <= d;
		model_load(la, index, d, core_reset);
		@(posedge clk_sys);
		load_wr <= 1'b0;
	endtask

	// we_n low for len cycles, data may change after the first
	task automatic write_pulse(input mem_addr_t a, input byte_t d, input int len,
			input bit late_change);
		@(posedge clk_sys);
		mem_addr  <= a;
		mem_wdata <= d;
		mem_we_n  <= 1'b0;
		model_write(a, d);
		for (int i = 1; i < len; i++) begin
			@(posedge clk_sys);
			if (late_change) begin
				mem_wdata <= ~d;
			end
		end
		@(posedge clk_sys);
		mem_we_n <= 1'b1;
	endtask

	// Every ROM slot, mirrors too, at the loaded offsets
	task automatic read_all_rom();
		mem_addr_t a;
		mem_idx_t  hit_idx;
		for (int s = 0; s < 16; s++) begin
			foreach (rom_used[i]) begin
				a = {5'(s), rom_used[i][OFF_W-1:0]};
				if (model_rom_map(a, hit_idx) && (hit_idx == rom_used[i])) begin
					read_check(a);
				end
			end
		end
	endtask

	task automatic mount_image(input bit nonempty);
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_nonempty <= nonempty;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		vsd_sel_m = nonempty;
	endtask

	// LED that shows card activity for the current select
	function automatic bit activity_led();
		return vsd_sel_m ? led_user : led_disk_act;
	endfunction

	task automatic wait_sd_idle();
		int n;
		n = 0;
		while ((led_user || led_disk_act) && (n < WAIT_LIMIT)) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			n++;
		end
		check_true(n < WAIT_LIMIT, "SD activity LEDs never went idle");
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic rom_load_readback();
		mem_idx_t idx;
		start_test();
		// Eight random offsets per bank, junk above bit 16
		for (int b = 0; b < 7; b++) begin
			for (int k = 0; k < 8; k++) begin
				idx = {3'(b), 14'(rand_below(1 << OFF_W))};
				rom_used.push_back(idx);
				load_byte({8'(rand_below(256)), idx}, LOAD_INDEX_ROM, 8'(rand_below(256)));
			end
		end
		@(posedge clk_sys);
		core_reset <= 1'b0;
		read_all_rom();
		end_test("rom load and readback");
	endtask

	task automatic loader_gating();
		mem_idx_t  idx;
		mem_addr_t a;
		start_test();
		// Core running, ROM index
		for (int k = 0; k < 8; k++) begin
			idx = rom_used[rand_below(rom_used.size())];
			load_byte({8'h00, idx}, LOAD_INDEX_ROM, 8'(rand_below(256)));
		end
		// Core in reset, other indexes
		@(posedge clk_sys);
		core_reset <= 1'b1;
		for (int k = 0; k < 8; k++) begin
			idx = rom_used[rand_below(rom_used.size())];
			load_byte({8'h00, idx}, 8'(1 + rand_below(255)), 8'(rand_below(256)));
		end
		@(posedge clk_sys);
		core_reset <= 1'b0;
		// Core writes aimed at ROM space
		for (int k = 0; k < 8; k++) begin
			idx = rom_used[rand_below(rom_used.size())];
			a = {1'b0, 4'(rand_below(16)), idx[OFF_W-1:0]};
			write_pulse(a, 8'(rand_below(256)), 1 + rand_below(3), 1'b0);
		end
		read_all_rom();
		// Empty slots, the upper RAM ones written first
		for (int s = 0; s < 32; s++) begin
			if ((s < 4) || (s >= 24)) begin
				a = {5'(s), 14'(rand_below(1 << OFF_W))};
				if (s >= 24) begin
					write_pulse(a, 8'(1 + rand_below(255)), 1, 1'b0);
				end
				read_check(a);
			end
		end
		end_test("loader gating and empty slots");
	endtask

	task automatic ram_random();
		mem_addr_t a;
		start_test();
		// Banks in turn, a read now and then in between
		for (int k = 0; k < 48; k++) begin
			a = {2'b10, 3'(k % 8), 14'(rand_below(1 << OFF_W))};
			write_pulse(a, 8'(rand_below(256)), 1 + rand_below(4), 1'(rand_below(2)));
			ram_used.push_back(a);
			if ((k % 4) == 3) begin
				read_check(ram_used[rand_below(ram_used.size())]);
			end
		end
		foreach (ram_used[i]) begin
			read_check(ram_used[i]);
		end
		end_test("sideways ram");
	endtask

	task automatic sd_routing();
		bit e_miso;
		bit e_sck;
		bit e_mosi;
		bit e_cs;
		bit e_ss;
		start_test();
		// Empty image first, then a real one
		for (int m = 0; m < 2; m++) begin
			mount_image(1'(m));
			repeat (32) begin
				@(posedge clk_sys);
				sd_sck    <= 1'(rand_below(2));
				sd_mosi   <= 1'(rand_below(2));
				sd_ss     <= 1'(rand_below(2));
				card_miso <= 1'(rand_below(2));
				vsd_miso  <= 1'(rand_below(2));
				@(negedge clk_sys);
				model_sd_route(vsd_sel_m, sd_sck, sd_mosi, sd_ss, card_miso, vsd_miso,
					e_miso, e_sck, e_mosi, e_cs, e_ss);
				check_val("sd_miso", sd_miso, e_miso);
				check_val("card_sck", card_sck, e_sck);
				check_val("card_mosi", card_mosi, e_mosi);
				check_val("card_cs", card_cs, e_cs);
				check_val("vsd_ss", vsd_ss, e_ss);
			end
		end
		end_test("sd routing");
	endtask

	task automatic activity_leds();
		int n;
		start_test();
		// Host card first, then the physical one
		for (int m = 1; m >= 0; m--) begin
			mount_image(1'(m));
			@(negedge clk_sys);
			wait_sd_idle();
			@(posedge clk_sys);
			sd_mosi <= ~sd_mosi;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_val("led_user", led_user, model_led_user(load_download, vsd_sel_m, 1'b1));
			check_val("led_disk_act", led_disk_act, model_led_disk(vsd_sel_m, 1'b1));
			// Cycles counted from the toggle edge
			n = 1;
			while (activity_led() && (n < WAIT_LIMIT)) begin
				@(posedge clk_sys);
				@(negedge clk_sys);
				n++;
			end
			check_true(n < WAIT_LIMIT, "activity LED never fell after the last toggle");
			check_true((n >= int'(HOLD)) && (n <= int'(HOLD) + 2),
				$sformatf("activity LED fell %0d cycles after the toggle", n));
			// Download LED with the card idle
			repeat (8) begin
				@(posedge clk_sys);
				load_download <= 1'(rand_below(2));
				@(negedge clk_sys);
				check_val("led_user", led_user, model_led_user(load_download, vsd_sel_m, 1'b0));
				check_val("led_disk_act", led_disk_act, model_led_disk(vsd_sel_m, 1'b0));
			end
			@(posedge clk_sys);
			load_download <= 1'b0;
		end
		end_test("activity leds");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk_sys = 1'b0;
		// Core held in reset so the loader owns ROM
		arst_n        <= 1'b0;
		core_reset    <= 1'b1;
		mem_addr      <= '0;
		mem_wdata     <= '0;
		mem_we_n      <= 1'b1;
		load_wr       <= 1'b0;
		load_addr     <= '0;
		load_index    <= '0;
		load_data     <= '0;
		load_download <= 1'b0;
		sd_sck        <= 1'b0;
		sd_mosi       <= 1'b0;
		sd_ss         <= 1'b1;
		card_miso     <= 1'b0;
		vsd_miso      <= 1'b0;
		img_mounted   <= 1'b0;
		img_nonempty  <= 1'b0;
		vsd_sel_m     = 1'b0;
		checks        = 0;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (16) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(posedge clk_sys);
		rom_load_readback();
		loader_gating();
		ram_random();
		sd_routing();
		activity_leds();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- hw/elk_glue_top.sv
// Board glue top for the Electron core
// Memory subsystem with ROM loader, SD routing with LEDs
module elk_glue_top
	import elk_mem_pkg::*;
	import elk_sd_pkg::*;
#(
	parameter act_cnt_t act_hold = ACT_HOLD_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       core_reset,
	// Core memory bus
	input  mem_addr_t  mem_addr,
	input  byte_t      mem_wdata,
	input  logic       mem_we_n,
	output byte_t      mem_rdata,
	// Host download port
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  byte_t      load_index,
	input  byte_t      load_data,
	input  logic       load_download,
	// Core SPI
	input  logic       sd_sck,
	input  logic       sd_mosi,
	input  logic       sd_ss,
	output logic       sd_miso,
	// Physical card
	output logic       card_sck,
	output logic       card_mosi,
	output logic       card_cs,
	input  logic       card_miso,
	// Host side card
	output logic       vsd_ss,
	input  logic       vsd_miso,
	input  logic       img_mounted,
	input  logic       img_nonempty,
	output logic       led_user,
	output logic       led_disk_act
);

	elk_mem_sys elk_mem_sys_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.core_reset (core_reset),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_we_n   (mem_we_n),
		.load_wr    (load_wr),
		.load_addr  (load_addr),
		.load_index (load_index),
		.load_data  (load_data),
		.mem_rdata  (mem_rdata)
	);

	elk_sd_route #(
		.act_hold (act_hold)
	) elk_sd_route_inst (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.sd_sck        (sd_sck),
		.sd_mosi       (sd_mosi),
		.sd_ss         (sd_ss),
		.card_miso     (card_miso),
		.vsd_miso      (vsd_miso),
		.img_mounted   (img_mounted),
		.img_nonempty  (img_nonempty),
		.load_download (load_download),
		.sd_miso       (sd_miso),
		.card_sck      (card_sck),
		.card_mosi     (card_mosi),
		.card_cs       (card_cs),
		.vsd_ss        (vsd_ss),
		.led_user      (led_user),
		.led_disk_act  (led_disk_act)
	);

endmodule

//--- hw/elk_sd_route.sv
// SD card routing between the core and two cards
// Virtual card select latched on image mount
// SPI mux to physical or host card, activity timer, LED drive
module elk_sd_route
	import elk_sd_pkg::*;
#(
	parameter act_cnt_t act_hold = ACT_HOLD_DEFAULT
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic sd_sck,
	input  logic sd_mosi,
	input  logic sd_ss,
	input  logic card_miso,
	input  logic vsd_miso,
	input  logic img_mounted,
	input  logic img_nonempty,
	input  logic load_download,
	output logic sd_miso,
	output logic card_sck,
	output logic card_mosi,
	output logic card_cs,
	output logic vsd_ss,
	output logic led_user,
	output logic led_disk_act
);

	logic     vsd_sel;
	logic     mosi_q;
	logic     miso_q;
	logic     toggle;
	logic     sd_act;
	act_cnt_t act_cnt;

	// Non-empty image selects the host card
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vsd_sel <= 1'b0;
		end else if (img_mounted) begin
			vsd_sel <= img_nonempty;
		end
	end

	////////////////////////////////////////////////////////////
	// SPI routing
	////////////////////////////////////////////////////////////

	// Unselected side held idle, chip select high
	assign card_cs   = sd_ss | vsd_sel;
	assign card_sck  = sd_sck & ~vsd_sel;
	assign card_mosi = sd_mosi & ~vsd_sel;
	assign vsd_ss    = sd_ss | ~vsd_sel;
	assign sd_miso   = vsd_sel ? vsd_miso : card_miso;

	////////////////////////////////////////////////////////////
	// Activity timer
	////////////////////////////////////////////////////////////

	// Previous line levels for toggle detect
	always_ff @(posedge clk_sys) begin
		mosi_q <= sd_mosi;
		miso_q <= sd_miso;
	end

	assign toggle = (mosi_q ^ sd_mosi) | (miso_q ^ sd_miso);

	// Parked at the hold limit when idle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			act_cnt <= act_hold;
		end else if (toggle) begin
			act_cnt <= '0;
		end else if (act_cnt != act_hold) begin
			act_cnt <= act_cnt + 1'b1;
		end
	end

	assign sd_act = (act_cnt != act_hold);

	// Download activity shares the user LED
	assign led_user     = load_download | (vsd_sel & sd_act);
	assign led_disk_act = ~vsd_sel & sd_act;

endmodule

//--- hw/elk_mem_sys.sv
// Memory subsystem for the Electron core bus
// ROM and sideways RAM arrays, bank decode
// Loader path into ROM while the core is in reset
// RAM write edge detect, read data select with empty slots at zero
module elk_mem_sys
	import elk_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       core_reset,
	input  mem_addr_t  mem_addr,
	input  byte_t      mem_wdata,
	input  logic       mem_we_n,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  byte_t      load_index,
	input  byte_t      load_data,
	output byte_t      mem_rdata
);

	mem_idx_t rom_idx;
	mem_idx_t ram_idx;
	logic     rom_hit;
	logic     ram_hit;
	mem_idx_t rom_addr;
	logic     rom_we;
	byte_t    rom_rdata;
	logic     ram_we;
	byte_t    ram_rdata;
	logic     we_n_q;

	elk_bank_decode elk_bank_decode_inst (
		.mem_addr (mem_addr),
		.rom_idx  (rom_idx),
		.ram_idx  (ram_idx),
		.rom_hit  (rom_hit),
		.ram_hit  (ram_hit)
	);

	////////////////////////////////////////////////////////////
	// ROM and loader
	////////////////////////////////////////////////////////////

	// Loader owns the ROM address during core reset
	assign rom_addr = core_reset ? load_addr[IDX_W-1:0] : rom_idx;
	// Only the ROM image index writes, and only in reset
	assign rom_we = load_wr & core_reset & (load_index == LOAD_INDEX_ROM);

	elk_spram #(
		.data_width (BYTE_W),
		.addr_width (IDX_W),
		.num_words  (ROM_WORDS)
	) rom_inst (
		.clk_sys (clk_sys),
		.addr    (rom_addr),
		.wdata   (load_data),
		.we      (rom_we),
		.rdata   (rom_rdata)
	);

	////////////////////////////////////////////////////////////
	// Sideways RAM
	////////////////////////////////////////////////////////////

	// Last sampled write strobe, idle high
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	// Falling edge of we_n only, one write per pulse
	// Unmapped RAM slots are dropped
	assign ram_we = ram_hit & we_n_q & ~mem_we_n;

	elk_spram #(
		.data_width (BYTE_W),
		.addr_width (IDX_W),
		.num_words  (RAM_WORDS)
	) ram_inst (
		.clk_sys (clk_sys),
		.addr    (ram_idx),
		.wdata   (mem_wdata),
		.we      (ram_we),
		.rdata   (ram_rdata)
	);

	// Read select on the live address, stable for the read
	always_comb begin
		if (mem_addr[RAM_SPACE_BIT]) begin
			mem_rdata = ram_hit ? ram_rdata : '0;
		end else begin
			mem_rdata = rom_hit ? rom_rdata : '0;
		end
	end

endmodule

//--- hw/elk_spram.sv
// Single port RAM with registered address
// Read data follows the address one edge later
// Written data shows on the next read of that word
module elk_spram #(
	parameter int data_width = 8,
	parameter int addr_width = 8,
	parameter int num_words  = 1 << addr_width
) (
	input  logic                  clk_sys,
	input  logic [addr_width-1:0] addr,
	input  logic [data_width-1:0] wdata,
	input  logic                  we,
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] mem [num_words];
	logic [addr_width-1:0] addr_q;

	always_ff @(posedge clk_sys) begin
		// Depth may be short of the full address range
		if (we && (int'(addr) < num_words)) begin
			mem[addr] <= wdata;
		end
		addr_q <= addr;
	end

	// New data on read during write
	assign rdata = mem[addr_q];

endmodule

//--- hw/elk_bank_decode.sv
// Slot to bank decode for the core memory bus
// ROM bank map with mirrored slot pairs
// Sideways RAM bank map, hit flags for both
module elk_bank_decode
	import elk_mem_pkg::*;
(
	input  mem_addr_t mem_addr,
	output mem_idx_t  rom_idx,
	output mem_idx_t  ram_idx,
	output logic      rom_hit,
	output logic      ram_hit
);

	slot_t             slot;
	bank_off_t         off;
	logic [BANK_W-1:0] rom_bank;
	logic [BANK_W-1:0] ram_bank;

	// Split the bus address
	assign slot = mem_addr[MEM_ADDR_W-1:OFF_W];
	assign off  = mem_addr[OFF_W-1:0];

	// ROM space, bit 18 clear
	always_comb begin
		rom_hit  = 1'b1;
		rom_bank = '0;
		case (slot)
			5'b0_01_00: rom_bank = 3'd0;
			// OS image seen twice
			5'b0_10_00,
			5'b0_10_01: rom_bank = 3'd1;
			// BASIC seen twice
			5'b0_10_10,
			5'b0_10_11: rom_bank = 3'd2;
			5'b0_11_00: rom_bank = 3'd3;
			5'b0_11_01: rom_bank = 3'd4;
			5'b0_11_10: rom_bank = 3'd5;
			5'b0_11_11: rom_bank = 3'd6;
			default: begin
				// Empty slot, reads as zero upstream
				rom_hit  = 1'b0;
				rom_bank = '0;
			end
		endcase
	end

	// RAM space, lower half of bit 18 set
	// Slots 1_00_00 to 1_01_11 map in order
	always_comb begin
		ram_hit  = (slot[SLOT_W-1 -: 2] == 2'b10);
		ram_bank = ram_hit ? slot[BANK_W-1:0] : '0;
	end

	// Offset passes straight through
	assign rom_idx = {rom_bank, off};
	assign ram_idx = {ram_bank, off};

endmodule

//--- hw/elk_sd_pkg.sv
// SD activity timer definitions
// Counter width and typedef, default LED hold time
package elk_sd_pkg;

	// Wide enough for the default hold
	localparam int ACT_CNT_W = 22;

	typedef logic [ACT_CNT_W-1:0] act_cnt_t;

	// Cycles of LED hold after the last SPI edge
	localparam act_cnt_t ACT_HOLD_DEFAULT = 22'd2000000;

endpackage

//--- hw/elk_mem_pkg.sv
// Memory map definitions for the Electron glue
// Bus, bank and loader widths with their typedefs
// ROM and RAM depths, loader index for the ROM image
package elk_mem_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int BYTE_W      = 8;
	localparam int MEM_ADDR_W  = 19;
	// Offset inside one 16 KB bank
	localparam int OFF_W       = 14;
	// Slot field sits above the offset
	localparam int SLOT_W      = MEM_ADDR_W - OFF_W;
	localparam int BANK_W      = 3;
	// Bank number on top of the offset
	localparam int IDX_W       = BANK_W + OFF_W;
	localparam int LOAD_ADDR_W = 25;

	// Top address bit picks sideways RAM space
	localparam int RAM_SPACE_BIT = MEM_ADDR_W - 1;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	typedef logic [BYTE_W-1:0]      byte_t;
	typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
	typedef logic [OFF_W-1:0]       bank_off_t;
	typedef logic [SLOT_W-1:0]      slot_t;
	typedef logic [IDX_W-1:0]       mem_idx_t;
	typedef logic [LOAD_ADDR_W-1:0] load_addr_t;

	////////////////////////////////////////////////////////////
	// Depths and loader
	////////////////////////////////////////////////////////////

	// Seven ROM banks
	localparam int ROM_WORDS = 114688;
	// Eight sideways RAM banks
	localparam int RAM_WORDS = 131072;

	// Only this download index goes to ROM
	localparam byte_t LOAD_INDEX_ROM = 8'd0;

endpackage
